// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = mem_subsystem_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)

// ==== design/axi_bank_router.sv ====
//##########################################################################
// AXI bank router
// steers AW, W and AR to the bank picked by the word address and returns
// the R and B of the bank that holds the transaction in flight
//##########################################################################

`timescale 1ns/100ps

`include "mem_consts.svh"

module axi_bank_router import axi_pkg::*; (
	input  logic                                clk,
	input  logic                                arst_n,
	input  axi_aw_t                             m_aw,
	output logic                                m_aw_ready,
	input  axi_w_t                              m_w,
	output logic                                m_w_ready,
	output axi_b_t                              m_b,
	input  axi_ar_t                             m_ar,
	output logic                                m_ar_ready,
	output axi_r_t                              m_r,
	output axi_aw_t [`MEM_NUM_BANKS-1:0]        s_aw,
	input  logic [`MEM_NUM_BANKS-1:0]           s_aw_ready,
	output axi_w_t [`MEM_NUM_BANKS-1:0]         s_w,
	input  logic [`MEM_NUM_BANKS-1:0]           s_w_ready,
	input  axi_b_t [`MEM_NUM_BANKS-1:0]         s_b,
	output axi_ar_t [`MEM_NUM_BANKS-1:0]        s_ar,
	input  logic [`MEM_NUM_BANKS-1:0]           s_ar_ready,
	input  axi_r_t [`MEM_NUM_BANKS-1:0]         s_r
);

	localparam int SEL_W = `MEM_BANK_SEL_W;

	logic [SEL_W-1:0] aw_sel;
	logic [SEL_W-1:0] w_sel;
	logic [SEL_W-1:0] ar_sel;
	logic [SEL_W-1:0] wr_bank_q;
	logic [SEL_W-1:0] rd_bank_q;

	assign aw_sel = m_aw.addr[`MEM_BANK_SEL_LSB +: SEL_W];
	assign ar_sel = m_ar.addr[`MEM_BANK_SEL_LSB +: SEL_W];
	// W has no address; after AW has gone, follow the recorded bank
	assign w_sel = m_aw.valid ? aw_sel : wr_bank_q;

	always_comb begin
		for (int i = 0; i < `MEM_NUM_BANKS; i++) begin
			s_aw[i] = m_aw;
			s_aw[i].valid = m_aw.valid && (aw_sel == SEL_W'(i));
			s_w[i] = m_w;
			s_w[i].valid = m_w.valid && (w_sel == SEL_W'(i));
			s_ar[i] = m_ar;
			s_ar[i].valid = m_ar.valid && (ar_sel == SEL_W'(i));
		end
	end

	assign m_aw_ready = s_aw_ready[aw_sel];
	assign m_w_ready = s_w_ready[w_sel];
	assign m_ar_ready = s_ar_ready[ar_sel];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_bank_q <= '0;
			rd_bank_q <= '0;
		end else begin
			if (m_aw.valid && m_aw_ready)
				wr_bank_q <= aw_sel;
			if (m_ar.valid && m_ar_ready)
				rd_bank_q <= ar_sel;
		end
	end

	// return path
	assign m_b = s_b[wr_bank_q];
	assign m_r = s_r[rd_bank_q];

endmodule

// ==== design/axi_master_arbiter.sv ====
//##########################################################################
// AXI master arbiter
// maps fetch and load/store request levels onto single-beat AXI reads and
// writes, fetch has priority on the read side
//##########################################################################

`timescale 1ns/100ps

`include "mem_consts.svh"

module axi_master_arbiter import axi_pkg::*, cpu_port_pkg::*; (
	input  logic                   clk,
	input  logic                   arst_n,
	input  fetch_req_t             fetch,
	output logic [`MEM_DATA_W-1:0] inst,
	output logic                   inst_valid,
	input  lsu_req_t               lsu,
	output logic [`MEM_DATA_W-1:0] rdata,
	output logic                   data_valid,
	output axi_aw_t                aw,
	input  logic                   aw_ready,
	output axi_w_t                 w,
	input  logic                   w_ready,
	input  axi_b_t                 b,
	output logic                   b_ready,
	output axi_ar_t                ar,
	input  logic                   ar_ready,
	input  axi_r_t                 r,
	output logic                   r_ready
);

	typedef enum logic [1:0] {W_IDLE, W_ADDR, W_DATA, W_RESP} wr_state_t;
	typedef enum logic [1:0] {R_IDLE, R_ADDR, R_READ} rd_state_t;

	wr_state_t wr_state;
	rd_state_t rd_state;
	logic      w_sent;
	logic      grant_fetch;
	logic      aw_fire;
	logic      w_fire;
	logic      ar_fire;
	logic      b_done;
	logic      r_done;

	assign aw_fire = aw.valid && aw_ready;
	assign w_fire = w.valid && w_ready;
	assign ar_fire = ar.valid && ar_ready;
	assign b_done = (wr_state == W_RESP) && b.valid && (b.id == AXI_ID_LSU);
	assign r_done = (rd_state == R_READ) && r.valid && r.last && (r.id == ar.id);

	// write side, AW and W may transfer in either order
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_state <= W_IDLE;
			w_sent <= 1'b0;
		end else begin
			case (wr_state)
				W_IDLE: begin
					if (lsu.we)
						wr_state <= W_ADDR;
				end
				W_ADDR: begin
					if (aw_fire) begin
						wr_state <= (w_fire || w_sent) ? W_RESP : W_DATA;
						w_sent <= 1'b0;
					end else if (w_fire) begin
						w_sent <= 1'b1;
					end
				end
				W_DATA: begin
					if (w_fire)
						wr_state <= W_RESP;
				end
				W_RESP: begin
					if (b_done)
						wr_state <= W_IDLE;
				end
				default: wr_state <= W_IDLE;
			endcase
		end
	end

	// read side, one owner at a time
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_state <= R_IDLE;
			grant_fetch <= 1'b0;
		end else begin
			case (rd_state)
				R_IDLE: begin
					if (fetch.ena || lsu.re) begin
						grant_fetch <= fetch.ena;
						rd_state <= R_ADDR;
					end
				end
				R_ADDR: begin
					if (ar_fire)
						rd_state <= R_READ;
				end
				R_READ: begin
					if (r_done)
						rd_state <= R_IDLE;
				end
				default: rd_state <= R_IDLE;
			endcase
		end
	end

	assign aw = '{id: AXI_ID_LSU, addr: lsu.addr, size: lsu.size,
		valid: wr_state == W_ADDR};
	assign w = '{data: lsu.wdata, strb: lsu.wmask, last: 1'b1,
		valid: ((wr_state == W_ADDR) && !w_sent) || (wr_state == W_DATA)};
	assign ar = '{id: grant_fetch ? AXI_ID_FETCH : AXI_ID_LSU,
		addr: grant_fetch ? fetch.addr : lsu.addr,
		size: grant_fetch ? fetch.size : lsu.size,
		valid: rd_state == R_ADDR};

	// responses are never back-pressured
	assign b_ready = 1'b1;
	assign r_ready = 1'b1;

	assign inst = r.data;
	assign rdata = r.data;
	assign inst_valid = r_done && grant_fetch;
	assign data_valid = (r_done && !grant_fetch) || b_done;

endmodule

// ==== design/axi_mem_bank.sv ====
//##########################################################################
// AXI memory bank
// single-beat slave over a word array with byte strobes, one read and one
// write outstanding
//##########################################################################

`timescale 1ns/100ps

`include "mem_consts.svh"

module axi_mem_bank import axi_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	input  axi_aw_t aw,
	output logic    aw_ready,
	input  axi_w_t  w,
	output logic    w_ready,
	output axi_b_t  b,
	input  axi_ar_t ar,
	output logic    ar_ready,
	output axi_r_t  r
);

	localparam int IDX_LSB = `MEM_BANK_SEL_LSB + `MEM_BANK_SEL_W;

	logic [`MEM_DATA_W-1:0] mem [`MEM_BANK_DEPTH];
	axi_aw_t aw_q;
	axi_w_t  w_q;
	axi_b_t  b_q;
	axi_r_t  r_q;
	axi_aw_t aw_cur;
	axi_w_t  w_cur;
	logic    aw_fire;
	logic    w_fire;
	logic    wr_go;
	logic [`MEM_BANK_IDX_W-1:0] wr_idx;
	logic [`MEM_BANK_IDX_W-1:0] rd_idx;

	assign aw_ready = !aw_q.valid && !b_q.valid;
	assign w_ready = !w_q.valid && !b_q.valid;
	assign ar_ready = !r_q.valid;
	assign aw_fire = aw.valid && aw_ready;
	assign w_fire = w.valid && w_ready;

	// held halves take the place of the live channel
	assign aw_cur = aw_q.valid ? aw_q : aw;
	assign w_cur = w_q.valid ? w_q : w;
	assign wr_go = (aw_q.valid || aw_fire) && (w_q.valid || w_fire);
	assign wr_idx = aw_cur.addr[IDX_LSB +: `MEM_BANK_IDX_W];
	assign rd_idx = ar.addr[IDX_LSB +: `MEM_BANK_IDX_W];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			aw_q <= '0;
			w_q <= '0;
			b_q <= '0;
		end else begin
			b_q.valid <= 1'b0;
			if (wr_go) begin
				aw_q.valid <= 1'b0;
				w_q.valid <= 1'b0;
				b_q <= '{id: aw_cur.id, resp: AXI_RESP_OKAY, valid: 1'b1};
			end else begin
				if (aw_fire)
					aw_q <= aw;
				if (w_fire)
					w_q <= w;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int k = 0; k < `MEM_BANK_DEPTH; k++)
				mem[k] <= '0;
		end else if (wr_go) begin
			for (int i = 0; i < `MEM_STRB_W; i++) begin
				if (w_cur.strb[i])
					mem[wr_idx][8*i +: 8] <= w_cur.data[8*i +: 8];
			end
		end
	end

	// full word, size is not used for reads
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			r_q <= '0;
		end else if (ar.valid && ar_ready) begin
			r_q <= '{id: ar.id, data: mem[rd_idx], resp: AXI_RESP_OKAY,
				last: 1'b1, valid: 1'b1};
		end else begin
			r_q.valid <= 1'b0;
		end
	end

	assign b = b_q;
	assign r = r_q;

endmodule

// ==== design/axi_pkg.sv ====
//##########################################################################
// AXI channel types
// single-beat payloads of the five channels, each with its valid bit
//##########################################################################

`include "mem_consts.svh"

package axi_pkg;

	typedef logic [1:0] axi_resp_t;

	localparam logic [`MEM_ID_W-1:0] AXI_ID_FETCH = `MEM_ID_W'(1);
	localparam logic [`MEM_ID_W-1:0] AXI_ID_LSU = `MEM_ID_W'(2);
	localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

	typedef struct packed {
		logic [`MEM_ID_W-1:0]   id;
		logic [`MEM_ADDR_W-1:0] addr;
		logic [`MEM_SIZE_W-1:0] size;
		logic                   valid;
	} axi_aw_t;

	typedef struct packed {
		logic [`MEM_DATA_W-1:0] data;
		logic [`MEM_STRB_W-1:0] strb;
		logic                   last;
		logic                   valid;
	} axi_w_t;

	typedef struct packed {
		logic [`MEM_ID_W-1:0] id;
		axi_resp_t            resp;
		logic                 valid;
	} axi_b_t;

	typedef struct packed {
		logic [`MEM_ID_W-1:0]   id;
		logic [`MEM_ADDR_W-1:0] addr;
		logic [`MEM_SIZE_W-1:0] size;
		logic                   valid;
	} axi_ar_t;

	typedef struct packed {
		logic [`MEM_ID_W-1:0]   id;
		logic [`MEM_DATA_W-1:0] data;
		axi_resp_t              resp;
		logic                   last;
		logic                   valid;
	} axi_r_t;

endpackage

// ==== design/cpu_port_pkg.sv ====
//##########################################################################
// CPU client request types
// fetch and load/store requests, held by the client until the valid pulse
//##########################################################################

`include "mem_consts.svh"

package cpu_port_pkg;

	typedef struct packed {
		logic [`MEM_ADDR_W-1:0] addr;
		logic [`MEM_SIZE_W-1:0] size;
		logic                   ena;
	} fetch_req_t;

	// re and we are never high together
	typedef struct packed {
		logic [`MEM_ADDR_W-1:0] addr;
		logic [`MEM_DATA_W-1:0] wdata;
		logic [`MEM_STRB_W-1:0] wmask;
		logic [`MEM_SIZE_W-1:0] size;
		logic                   re;
		logic                   we;
	} lsu_req_t;

endpackage

// ==== design/mem_consts.svh ====
//##########################################################################
// memory subsystem constants
// widths of the AXI fields and the bank geometry, banks interleave by word
//##########################################################################

`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

`define MEM_ADDR_W       32
`define MEM_DATA_W       64
`define MEM_STRB_W       8
`define MEM_ID_W         4
`define MEM_SIZE_W       3
`define MEM_NUM_BANKS    4
`define MEM_BANK_DEPTH   64
`define MEM_BANK_SEL_LSB 3
`define MEM_BANK_SEL_W   $clog2(`MEM_NUM_BANKS)
`define MEM_BANK_IDX_W   $clog2(`MEM_BANK_DEPTH)

`endif

// ==== design/mem_subsystem_top.sv ====
//##########################################################################
// memory subsystem top
// arbiter, bank router and the array of memory banks
//##########################################################################

`timescale 1ns/100ps

`include "mem_consts.svh"

module mem_subsystem_top import axi_pkg::*, cpu_port_pkg::*; (
	input  logic                   clk,
	input  logic                   arst_n,
	input  fetch_req_t             fetch,
	output logic [`MEM_DATA_W-1:0] inst,
	output logic                   inst_valid,
	input  lsu_req_t               lsu,
	output logic [`MEM_DATA_W-1:0] rdata,
	output logic                   data_valid
);

	axi_aw_t aw;
	axi_w_t  w;
	axi_b_t  b;
	axi_ar_t ar;
	axi_r_t  r;
	logic    aw_ready;
	logic    w_ready;
	logic    ar_ready;

	axi_aw_t [`MEM_NUM_BANKS-1:0] s_aw;
	axi_w_t [`MEM_NUM_BANKS-1:0]  s_w;
	axi_b_t [`MEM_NUM_BANKS-1:0]  s_b;
	axi_ar_t [`MEM_NUM_BANKS-1:0] s_ar;
	axi_r_t [`MEM_NUM_BANKS-1:0]  s_r;
	logic [`MEM_NUM_BANKS-1:0]    s_aw_ready;
	logic [`MEM_NUM_BANKS-1:0]    s_w_ready;
	logic [`MEM_NUM_BANKS-1:0]    s_ar_ready;

	// banks never stall responses, so b_ready and r_ready go nowhere
	axi_master_arbiter u_arbiter (
		.clk        (clk),
		.arst_n     (arst_n),
		.fetch      (fetch),
		.inst       (inst),
		.inst_valid (inst_valid),
		.lsu        (lsu),
		.rdata      (rdata),
		.data_valid (data_valid),
		.aw         (aw),
		.aw_ready   (aw_ready),
		.w          (w),
		.w_ready    (w_ready),
		.b          (b),
		.b_ready    (),
		.ar         (ar),
		.ar_ready   (ar_ready),
		.r          (r),
		.r_ready    ()
	);

	axi_bank_router u_router (
		.clk        (clk),
		.arst_n     (arst_n),
		.m_aw       (aw),
		.m_aw_ready (aw_ready),
		.m_w        (w),
		.m_w_ready  (w_ready),
		.m_b        (b),
		.m_ar       (ar),
		.m_ar_ready (ar_ready),
		.m_r        (r),
		.s_aw       (s_aw),
		.s_aw_ready (s_aw_ready),
		.s_w        (s_w),
		.s_w_ready  (s_w_ready),
		.s_b        (s_b),
		.s_ar       (s_ar),
		.s_ar_ready (s_ar_ready),
		.s_r        (s_r)
	);

	for (genvar g = 0; g < `MEM_NUM_BANKS; g++) begin : g_bank
		axi_mem_bank u_bank (
			.clk      (clk),
			.arst_n   (arst_n),
			.aw       (s_aw[g]),
			.aw_ready (s_aw_ready[g]),
			.w        (s_w[g]),
			.w_ready  (s_w_ready[g]),
			.b        (s_b[g]),
			.ar       (s_ar[g]),
			.ar_ready (s_ar_ready[g]),
			.r        (s_r[g])
		);
	end

endmodule

// ==== src.f ====
+incdir+design
design/axi_pkg.sv
design/cpu_port_pkg.sv
design/axi_master_arbiter.sv
design/axi_bank_router.sv
design/axi_mem_bank.sv
design/mem_subsystem_top.sv
verif/mem_subsystem_properties.sv
verif/mem_subsystem_tb.sv

// ==== verif/mem_subsystem_properties.sv ====
//##########################################################################
// arbiter AXI checks
// handshake stability, inst pulse width and idle valids around reset
//##########################################################################

`timescale 1ns/100ps

module mem_subsystem_properties import axi_pkg::*; (
	input logic    clk,
	input logic    arst_n,
	input axi_aw_t aw,
	input logic    aw_ready,
	input axi_w_t  w,
	input logic    w_ready,
	input axi_ar_t ar,
	input logic    ar_ready,
	input logic    inst_valid
);

	// pending transfers keep valid and payload
	aw_stable: assert property (@(posedge clk) disable iff (!arst_n)
		aw.valid && !aw_ready |=> $stable(aw))
		else $error("aw changed before aw_ready");

	w_stable: assert property (@(posedge clk) disable iff (!arst_n)
		w.valid && !w_ready |=> $stable(w))
		else $error("w changed before w_ready");

	ar_stable: assert property (@(posedge clk) disable iff (!arst_n)
		ar.valid && !ar_ready |=> $stable(ar))
		else $error("ar changed before ar_ready");

	inst_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		inst_valid |=> !inst_valid)
		else $error("inst_valid high for two cycles");

	reset_idle: assert property (@(posedge clk)
		!arst_n || $rose(arst_n) |-> !aw.valid && !w.valid && !ar.valid)
		else $error("AXI valid high around reset");

endmodule

bind axi_master_arbiter mem_subsystem_properties u_props (
	.clk        (clk),
	.arst_n     (arst_n),
	.aw         (aw),
	.aw_ready   (aw_ready),
	.w          (w),
	.w_ready    (w_ready),
	.ar         (ar),
	.ar_ready   (ar_ready),
	.inst_valid (inst_valid)
);

// ==== verif/mem_subsystem_tb.sv ====
//##########################################################################
// memory subsystem testbench
// table of fetch, load and store requests checked against a shadow memory
//##########################################################################

`timescale 1ns/100ps

`include "mem_consts.svh"

module mem_subsystem_tb import cpu_port_pkg::*; ();

	localparam int RESET_CYCLES = 5;
	localparam int LAT_SINGLE = 2;
	localparam int N_TESTS = 18;
	localparam int TIMEOUT_CYCLES = N_TESTS * 10 + RESET_CYCLES;
	localparam int SHADOW_WORDS = `MEM_NUM_BANKS * `MEM_BANK_DEPTH;
	localparam int SHADOW_IDX_W = $clog2(SHADOW_WORDS);
	localparam logic [1:0] OP_FETCH = 2'd0;
	localparam logic [1:0] OP_LOAD = 2'd1;
	localparam logic [1:0] OP_STORE = 2'd2;
	localparam logic [1:0] OP_BOTH = 2'd3;

	typedef struct packed {
		logic [1:0]             op;
		logic [31:0]            word;
		logic [`MEM_STRB_W-1:0] mask;
		logic [3:0]             lat;
	} test_entry_t;

	logic                   clk;
	logic                   arst_n;
	fetch_req_t             fetch;
	lsu_req_t               lsu;
	logic [`MEM_DATA_W-1:0] inst;
	logic                   inst_valid;
	logic [`MEM_DATA_W-1:0] rdata;
	logic                   data_valid;

	test_entry_t            tests [N_TESTS];
	logic [`MEM_DATA_W-1:0] shadow [SHADOW_WORDS];
	logic [31:0]            lfsr;
	int                     cycle_count;

	mem_subsystem_top dut (
		.clk        (clk),
		.arst_n     (arst_n),
		.fetch      (fetch),
		.inst       (inst),
		.inst_valid (inst_valid),
		.lsu        (lsu),
		.rdata      (rdata),
		.data_valid (data_valid)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: the DUT gave no result within %0d cycles", cycle_count);
			$display("*** FAILED ***");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hd0000001) : (s >> 1);
	endfunction

	function automatic logic [31:0] byte_addr(input logic [31:0] word);
		return word << $clog2(`MEM_DATA_W / 8);
	endfunction

	task automatic random_word(output logic [`MEM_DATA_W-1:0] v);
		v = '0;
		for (int i = 0; i < `MEM_DATA_W; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[`MEM_DATA_W-2:0], lfsr[0]};
		end
	endtask

	task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
		input string what);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			$display("*** FAILED ***");
			$fatal(1, "value mismatch");
		end
	endtask

	// samples at the falling edge, counts rising edges until the pulse
	task automatic wait_pulse(input logic want_inst, inout int cyc);
		logic seen;
		seen = 1'b0;
		while (!seen) begin
			@(negedge clk);
			if (want_inst) begin
				check_value(64'(data_valid), 64'd0, "data_valid while fetching");
				seen = inst_valid;
			end else begin
				check_value(64'(inst_valid), 64'd0, "inst_valid during load or store");
				seen = data_valid;
			end
			if (!seen) begin
				@(posedge clk);
				cyc++;
			end
		end
	endtask

	initial begin
		test_entry_t                e;
		logic [`MEM_DATA_W-1:0]     wdata;
		logic [SHADOW_IDX_W-1:0]    idx;
		int                         cyc;
		clk = 1'b0;
		arst_n = 1'b0;
		cycle_count = 0;
		lfsr = 32'h447edbcd;
		fetch = '0;
		lsu = '0;
		for (int k = 0; k < SHADOW_WORDS; k++)
			shadow[k] = '0;

		// one store per bank, then read back
		tests[0] = '{OP_STORE, 32'd0, 8'hff, 4'd2};
		tests[1] = '{OP_STORE, 32'd1, 8'hff, 4'd2};
		tests[2] = '{OP_STORE, 32'd2, 8'hff, 4'd2};
		tests[3] = '{OP_STORE, 32'd3, 8'hff, 4'd2};
		tests[4] = '{OP_LOAD, 32'd0, 8'h00, 4'd2};
		tests[5] = '{OP_LOAD, 32'd1, 8'h00, 4'd2};
		tests[6] = '{OP_LOAD, 32'd2, 8'h00, 4'd2};
		tests[7] = '{OP_LOAD, 32'd3, 8'h00, 4'd2};
		// partial masks
		tests[8] = '{OP_STORE, 32'd1, 8'h0f, 4'd2};
		tests[9] = '{OP_LOAD, 32'd1, 8'h00, 4'd2};
		tests[10] = '{OP_STORE, 32'd5, 8'ha5, 4'd2};
		tests[11] = '{OP_LOAD, 32'd5, 8'h00, 4'd2};
		tests[12] = '{OP_FETCH, 32'd2, 8'h00, 4'd2};
		// fetch of word 0 with a load of word 1 behind it
		tests[13] = '{OP_BOTH, 32'd0, 8'h00, 4'd5};
		// wrap past the end of memory
		tests[14] = '{OP_LOAD, 32'd257, 8'h00, 4'd2};
		tests[15] = '{OP_STORE, 32'd514, 8'hf0, 4'd2};
		tests[16] = '{OP_FETCH, 32'd2, 8'h00, 4'd2};
		tests[17] = '{OP_FETCH, 32'd6, 8'h00, 4'd2};

		repeat (RESET_CYCLES) @(posedge clk);
		#1 arst_n = 1'b1;

		for (int t = 0; t < N_TESTS; t++) begin
			e = tests[t];
			idx = e.word[SHADOW_IDX_W-1:0];
			cyc = 0;
			@(posedge clk);
			#1;
			case (e.op)
				OP_STORE: begin
					random_word(wdata);
					lsu.addr = byte_addr(e.word);
					lsu.wdata = wdata;
					lsu.wmask = e.mask;
					lsu.size = 3'd3;
					lsu.we = 1'b1;
					for (int i = 0; i < `MEM_STRB_W; i++) begin
						if (e.mask[i])
							shadow[idx][8*i +: 8] = wdata[8*i +: 8];
					end
					wait_pulse(1'b0, cyc);
				end
				OP_LOAD: begin
					lsu.addr = byte_addr(e.word);
					lsu.size = 3'd3;
					lsu.re = 1'b1;
					wait_pulse(1'b0, cyc);
					check_value(rdata, shadow[idx], "load data");
				end
				OP_FETCH: begin
					fetch.addr = byte_addr(e.word);
					fetch.size = 3'd3;
					fetch.ena = 1'b1;
					wait_pulse(1'b1, cyc);
					check_value(inst, shadow[idx], "fetched word");
				end
				OP_BOTH: begin
					fetch.addr = byte_addr(e.word);
					fetch.size = 3'd3;
					fetch.ena = 1'b1;
					lsu.addr = byte_addr(e.word + 32'd1);
					lsu.size = 3'd3;
					lsu.re = 1'b1;
					wait_pulse(1'b1, cyc);
					check_value(inst, shadow[idx], "fetched word with load waiting");
					check_value(64'(cyc), 64'(LAT_SINGLE), "fetch latency with load waiting");
					@(posedge clk);
					cyc++;
					#1 fetch = '0;
					wait_pulse(1'b0, cyc);
					check_value(rdata, shadow[idx + 1'b1], "load data behind fetch");
				end
			endcase
			check_value(64'(cyc), 64'(e.lat), "request latency");
			@(posedge clk);
			#1;
			fetch = '0;
			lsu = '0;
		end

		$display("*** PASSED ***");
		$finish;
	end

endmodule
